/* logic/mem_pkg.sv */
package mem_pkg;

    // RV32 data path widths
    localparam int ADDRESS_WIDTH = 32;
    localparam int DATA_WIDTH = 32;

    // load width codes from the func3 field
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LBU = 3'b100,
        LHU = 3'b101
    } func3_t;

    // store codes reuse the load encodings
    localparam func3_t SB = LB;
    localparam func3_t SH = LH;
    localparam func3_t SW = LW;

    // request sampled on acceptance
    typedef struct packed {
        func3_t                   func3;
        logic [ADDRESS_WIDTH-1:0] address;
        logic [DATA_WIDTH-1:0]    wdata;
    } mem_req_t;

    // command from the controller to the word memory
    typedef struct packed {
        logic                     read;
        logic                     write;
        logic [ADDRESS_WIDTH-1:0] address;
        logic [DATA_WIDTH-1:0]    wdata;
    } ram_cmd_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD_WAIT,
        LOAD_DONE,
        MERGE_WAIT,
        STORE_WRITE
    } ctrl_state_t;

endpackage : mem_pkg

/* logic/data_ram.sv */
`timescale 1ns/1ps

module data_ram #(
    parameter int MEMORY_DEPTH = 4096,
    parameter int READ_LATENCY = 2
) (
    input  logic                             clk,
    input  mem_pkg::ram_cmd_t                cmd,
    output logic [mem_pkg::DATA_WIDTH-1:0]   rdata
);

    import mem_pkg::*;

    // depth is a power of two, so the low address bits wrap the index
    localparam int INDEX_WIDTH = $clog2(MEMORY_DEPTH);

    logic [DATA_WIDTH-1:0]  mem [MEMORY_DEPTH];
    logic [INDEX_WIDTH-1:0] index;

    // stage 0 is the array output register, the rest model wire delay
    logic [DATA_WIDTH-1:0]  delay_q [READ_LATENCY];

    assign index = cmd.address[INDEX_WIDTH-1:0];

    // write wins over read when both strobes are set
    always_ff @(posedge clk) begin
        if (cmd.write) begin
            mem[index] <= cmd.wdata;
        end
        else if (cmd.read) begin
            delay_q[0] <= mem[index];
        end
    end

    // remaining stages shift every cycle
    // so the output settles and holds until the next read
    for (genvar i = 1; i < READ_LATENCY; i++) begin : g_delay
        always_ff @(posedge clk) begin
            delay_q[i] <= delay_q[i-1];
        end
    end

    assign rdata = delay_q[READ_LATENCY-1];

endmodule : data_ram

/* logic/subword_unit.sv */
`timescale 1ns/1ps

module subword_unit (
    input  mem_pkg::func3_t                  func3,
    input  logic [mem_pkg::DATA_WIDTH-1:0]   word,
    input  logic [mem_pkg::DATA_WIDTH-1:0]   wdata,
    output logic [mem_pkg::DATA_WIDTH-1:0]   load_data,
    output logic [mem_pkg::DATA_WIDTH-1:0]   store_data
);

    import mem_pkg::*;

    localparam int BYTE_WIDTH = 8;
    localparam int HALF_WIDTH = DATA_WIDTH / 2;

    logic [BYTE_WIDTH-1:0] word_byte;
    logic [HALF_WIDTH-1:0] word_half;

    // sub-word fields always come from the low end of the word
    assign word_byte = word[BYTE_WIDTH-1:0];
    assign word_half = word[HALF_WIDTH-1:0];

    // load formatting
    always_comb begin
        case (func3)
            LB: begin
                load_data = {{(DATA_WIDTH-BYTE_WIDTH){word_byte[BYTE_WIDTH-1]}}, word_byte};
            end
            LH: begin
                load_data = {{(DATA_WIDTH-HALF_WIDTH){word_half[HALF_WIDTH-1]}}, word_half};
            end
            LBU: begin
                load_data = {{(DATA_WIDTH-BYTE_WIDTH){1'b0}}, word_byte};
            end
            LHU: begin
                load_data = {{(DATA_WIDTH-HALF_WIDTH){1'b0}}, word_half};
            end
            // LW and unknown codes return the whole word
            default: begin
                load_data = word;
            end
        endcase
    end

    // store merge keeps the upper bits of the old word
    always_comb begin
        case (func3)
            SB: begin
                store_data = {word[DATA_WIDTH-1:BYTE_WIDTH], wdata[BYTE_WIDTH-1:0]};
            end
            SH: begin
                store_data = {word[DATA_WIDTH-1:HALF_WIDTH], wdata[HALF_WIDTH-1:0]};
            end
            default: begin
                store_data = wdata;
            end
        endcase
    end

endmodule : subword_unit

/* logic/mem_controller.sv */
`timescale 1ns/1ps

module mem_controller #(
    parameter int READ_LATENCY = 2
) (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic                             read_en,
    input  logic                             write_en,
    input  mem_pkg::mem_req_t                req,
    input  logic [mem_pkg::DATA_WIDTH-1:0]   rdata,
    output mem_pkg::ram_cmd_t                cmd,
    output logic [mem_pkg::DATA_WIDTH-1:0]   data_out,
    output logic                             ready
);

    import mem_pkg::*;

    // counter must reach READ_LATENCY itself
    localparam int CNT_WIDTH = $clog2(READ_LATENCY + 1);

    ctrl_state_t           state_q, state_d;
    logic [CNT_WIDTH-1:0]  cnt_q, cnt_d;
    ram_cmd_t              cmd_q, cmd_d;
    mem_req_t              req_q, req_d;
    logic [DATA_WIDTH-1:0] data_out_q, data_out_d;
    logic                  ready_q, ready_d;

    logic [DATA_WIDTH-1:0] load_data;
    logic [DATA_WIDTH-1:0] store_data;
    logic                  wait_done;
    logic                  subword_store;

    // formatting works on the held func3 and wdata
    subword_unit subword_unit_i (
        .func3      (req_q.func3),
        .word       (rdata),
        .wdata      (req_q.wdata),
        .load_data  (load_data),
        .store_data (store_data)
    );

    assign wait_done = (cnt_q == CNT_WIDTH'(READ_LATENCY));

    // byte and halfword stores need the old word first
    assign subword_store = (req.func3 == SB) || (req.func3 == SH);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state_q    <= IDLE;
            cnt_q      <= '0;
            cmd_q      <= '0;
            data_out_q <= '0;
            ready_q    <= 1'b1;
        end
        else begin
            state_q    <= state_d;
            cnt_q      <= cnt_d;
            cmd_q      <= cmd_d;
            data_out_q <= data_out_d;
            ready_q    <= ready_d;
        end
    end

    // request held for the whole operation
    always_ff @(posedge clk) begin
        req_q <= req_d;
    end

    always_comb begin
        state_d    = state_q;
        cnt_d      = cnt_q;
        cmd_d      = cmd_q;
        req_d      = req_q;
        data_out_d = data_out_q;
        ready_d    = ready_q;

        case (state_q)
            IDLE: begin
                if (read_en || write_en) begin
                    req_d         = req;
                    cnt_d         = '0;
                    ready_d       = 1'b0;
                    cmd_d.address = req.address;
                    // read has priority over write
                    if (read_en) begin
                        cmd_d.read = 1'b1;
                        state_d    = LOAD_WAIT;
                    end
                    else if (subword_store) begin
                        cmd_d.read = 1'b1;
                        state_d    = MERGE_WAIT;
                    end
                    else begin
                        cmd_d.write = 1'b1;
                        cmd_d.wdata = req.wdata;
                        state_d     = STORE_WRITE;
                    end
                end
            end

            LOAD_WAIT: begin
                cmd_d.read = 1'b0;
                if (wait_done) begin
                    state_d = LOAD_DONE;
                end
                else begin
                    cnt_d = cnt_q + 1'b1;
                end
            end

            LOAD_DONE: begin
                data_out_d = load_data;
                ready_d    = 1'b1;
                state_d    = IDLE;
            end

            MERGE_WAIT: begin
                cmd_d.read = 1'b0;
                if (wait_done) begin
                    state_d = STORE_WRITE;
                end
                else begin
                    cnt_d = cnt_q + 1'b1;
                end
            end

            // first pass issues the merged write, second pass retires it
            STORE_WRITE: begin
                if (cmd_q.write) begin
                    cmd_d.write = 1'b0;
                    ready_d     = 1'b1;
                    state_d     = IDLE;
                end
                else begin
                    cmd_d.write   = 1'b1;
                    cmd_d.address = req_q.address;
                    cmd_d.wdata   = store_data;
                end
            end

            default: begin
                state_d = IDLE;
            end
        endcase
    end

    assign cmd      = cmd_q;
    assign data_out = data_out_q;
    assign ready    = ready_q;

endmodule : mem_controller

/* logic/mem_subsystem_top.sv */
`timescale 1ns/1ps

module mem_subsystem_top #(
    parameter int MEMORY_DEPTH = 4096,
    parameter int READ_LATENCY = 2
) (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic                             read_en,
    input  logic                             write_en,
    input  mem_pkg::mem_req_t                req,
    output logic [mem_pkg::DATA_WIDTH-1:0]   data_out,
    output logic                             ready
);

    import mem_pkg::*;

    ram_cmd_t              cmd;
    logic [DATA_WIDTH-1:0] rdata;

    // controller counts the same latency the memory models
    mem_controller #(
        .READ_LATENCY (READ_LATENCY)
    ) mem_controller_i (
        .clk      (clk),
        .rstN     (rstN),
        .read_en  (read_en),
        .write_en (write_en),
        .req      (req),
        .rdata    (rdata),
        .cmd      (cmd),
        .data_out (data_out),
        .ready    (ready)
    );

    data_ram #(
        .MEMORY_DEPTH (MEMORY_DEPTH),
        .READ_LATENCY (READ_LATENCY)
    ) data_ram_i (
        .clk   (clk),
        .cmd   (cmd),
        .rdata (rdata)
    );

endmodule : mem_subsystem_top

/* testbench/tb_mem_subsystem.sv */
`timescale 1ns/1ps

module tb_mem_subsystem;

    import mem_pkg::*;

    localparam int MEM_DEPTH = 64;
    localparam int READ_LAT  = 2;

    localparam logic [31:0] LFSR_SEED = 32'h6c9a_cc6b;

    // operation counts per test group
    localparam int N_ROUND = 40;
    localparam int N_EXT   = 8;
    localparam int N_SUB   = 16;
    localparam int N_PRIO  = 8;
    localparam int NUM_OPS = MEM_DEPTH + 2 * N_ROUND + 5 * N_EXT + 2 * N_SUB + 3 * N_PRIO;
    localparam int CYCLE_LIMIT = NUM_OPS * (READ_LAT + 4) + 100;

    // what the checker expects from one accepted request
    typedef struct packed {
        logic                     is_load;
        func3_t                   func3;
        logic [ADDRESS_WIDTH-1:0] address;
        logic [DATA_WIDTH-1:0]    expected;
        logic [7:0]               busy;
    } expect_t;

    logic                  clk;
    logic                  rstN;
    logic                  read_en;
    logic                  write_en;
    mem_req_t              req;
    logic [DATA_WIDTH-1:0] data_out;
    logic                  ready;

    logic [DATA_WIDTH-1:0] model_mem [MEM_DEPTH];
    logic [31:0]           lfsr_state;
    expect_t               pending [$];
    int                    ops_issued;
    int                    ops_done;
    int                    cycle_count;
    func3_t                ext_codes [4];

    mem_subsystem_top #(
        .MEMORY_DEPTH (MEM_DEPTH),
        .READ_LATENCY (READ_LAT)
    ) mem_subsystem_top_i (
        .clk      (clk),
        .rstN     (rstN),
        .read_en  (read_en),
        .write_en (write_en),
        .req      (req),
        .data_out (data_out),
        .ready    (ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // one LFSR step per bit taken
    task automatic draw(input int nbits, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    function automatic int index_of(input logic [ADDRESS_WIDTH-1:0] addr);
        return int'(addr % MEM_DEPTH);
    endfunction

    function automatic logic [DATA_WIDTH-1:0] fill_word(input int i);
        logic [31:0] a;
        a = i;
        return (a * 32'h9e37_79b9) ^ 32'h5a3c_96e1;
    endfunction

    // expected load value from the width and sign rules
    function automatic logic [DATA_WIDTH-1:0] format_load(input func3_t f,
                                                          input logic [DATA_WIDTH-1:0] word);
        logic [DATA_WIDTH-1:0] byte_part;
        logic [DATA_WIDTH-1:0] half_part;
        byte_part = word & 32'h0000_00ff;
        half_part = word & 32'h0000_ffff;
        case (f)
            LB:      return word[7] ? (byte_part | 32'hffff_ff00) : byte_part;
            LH:      return word[15] ? (half_part | 32'hffff_0000) : half_part;
            LBU:     return byte_part;
            LHU:     return half_part;
            default: return word;
        endcase
    endfunction

    // expected memory word after a store
    function automatic logic [DATA_WIDTH-1:0] merge_store(input func3_t f,
                                                          input logic [DATA_WIDTH-1:0] old,
                                                          input logic [DATA_WIDTH-1:0] wd);
        case (f)
            SB:      return (old & 32'hffff_ff00) | (wd & 32'h0000_00ff);
            SH:      return (old & 32'hffff_0000) | (wd & 32'h0000_ffff);
            default: return wd;
        endcase
    endfunction

    function automatic int busy_len(input logic rd, input func3_t f);
        if (rd) begin
            return READ_LAT + 2;
        end
        else if (f == SB || f == SH) begin
            return READ_LAT + 3;
        end
        return 1;
    endfunction

    function automatic string code_text(input func3_t f);
        string s;
        s = f.name();
        if (s == "") begin
            s = $sformatf("code %03b", f);
        end
        return s;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_word(input logic [DATA_WIDTH-1:0] actual,
                              input logic [DATA_WIDTH-1:0] expected,
                              input func3_t f, input logic [ADDRESS_WIDTH-1:0] addr);
        if (actual !== expected) begin
            report_failure($sformatf(
                "CHECK FAILED at %0t: data_out for %s at 0x%08h is 0x%08h, expected 0x%08h",
                $time, code_text(f), addr, actual, expected));
        end
    endtask

    task automatic check_ready(input logic actual, input logic expected,
                               input func3_t f, input logic [ADDRESS_WIDTH-1:0] addr);
        if (actual !== expected) begin
            report_failure($sformatf(
                "CHECK FAILED at %0t: ready for %s at 0x%08h is %b, expected %b",
                $time, code_text(f), addr, actual, expected));
        end
    endtask

    task automatic check_busy(input int actual, input int expected,
                              input func3_t f, input logic [ADDRESS_WIDTH-1:0] addr);
        ctrl_state_t st;
        st = mem_subsystem_top_i.mem_controller_i.state_q;
        if (actual != expected) begin
            report_failure($sformatf(
                "CHECK FAILED at %0t: %s at 0x%08h busy %0d cycles, expected %0d (state %s)",
                $time, code_text(f), addr, actual, expected, st.name()));
        end
    endtask

    // drive one request, hand its expectation to the checker, wait for it
    task automatic run_op(input logic rd, input logic wr, input func3_t f,
                          input logic [ADDRESS_WIDTH-1:0] addr,
                          input logic [DATA_WIDTH-1:0] wd);
        expect_t rec;
        rec.is_load  = rd;
        rec.func3    = f;
        rec.address  = addr;
        rec.busy     = 8'(busy_len(rd, f));
        rec.expected = '0;
        if (rd) begin
            rec.expected = format_load(f, model_mem[index_of(addr)]);
        end
        else begin
            model_mem[index_of(addr)] = merge_store(f, model_mem[index_of(addr)], wd);
        end
        ops_issued++;
        @(posedge clk);
        #1;
        read_en  = rd;
        write_en = wr;
        req      = '{func3: f, address: addr, wdata: wd};
        // acceptance edge
        @(posedge clk);
        #1;
        read_en  = 1'b0;
        write_en = 1'b0;
        pending.push_back(rec);
        wait (ops_done == ops_issued);
    endtask

    // checker samples on the falling edge
    initial begin
        expect_t               cur;
        logic                  in_flight;
        int                    low_cycles;
        logic [DATA_WIDTH-1:0] last_load;
        in_flight  = 1'b0;
        low_cycles = 0;
        last_load  = '0;
        cur        = '0;
        forever begin
            @(negedge clk);
            if (!in_flight) begin
                if (pending.size() > 0) begin
                    cur        = pending.pop_front();
                    in_flight  = 1'b1;
                    low_cycles = 1;
                    check_ready(ready, 1'b0, cur.func3, cur.address);
                end
            end
            else if (ready === 1'b0) begin
                low_cycles++;
            end
            else begin
                check_busy(low_cycles, int'(cur.busy), cur.func3, cur.address);
                // stores leave the last load result in place
                if (cur.is_load) begin
                    last_load = cur.expected;
                end
                check_word(data_out, last_load, cur.func3, cur.address);
                in_flight = 1'b0;
                ops_done++;
            end
        end
    end

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count >= CYCLE_LIMIT) begin
                report_failure($sformatf("timeout at %0t: run did not finish within %0d cycles",
                                         $time, CYCLE_LIMIT));
            end
        end
    end

    initial begin
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] r;
        logic [31:0] k;
        func3_t      f;
        read_en      = 1'b0;
        write_en     = 1'b0;
        req          = '0;
        rstN         = 1'b0;
        lfsr_state   = LFSR_SEED;
        ops_issued   = 0;
        ops_done     = 0;
        ext_codes[0] = LB;
        ext_codes[1] = LH;
        ext_codes[2] = LBU;
        ext_codes[3] = LHU;
        repeat (3) @(posedge clk);
        #1;
        rstN = 1'b1;

        check_ready(ready, 1'b1, LW, '0);
        check_word(data_out, '0, LW, '0);

        // known contents for every word
        for (int i = 0; i < MEM_DEPTH; i++) begin
            run_op(1'b0, 1'b1, SW, i, fill_word(i));
        end

        // word round trip with some codes outside the RV32 set
        for (int n = 0; n < N_ROUND; n++) begin
            draw(32, a);
            draw(32, d);
            draw(2, r);
            case (r[1:0])
                2'd2:    f = func3_t'(3'b011);
                2'd3:    f = LBU;
                default: f = SW;
            endcase
            run_op(1'b0, 1'b1, f, a, d);
            draw(2, r);
            case (r[1:0])
                2'd2:    f = func3_t'(3'b011);
                2'd3:    f = func3_t'(3'b111);
                default: f = LW;
            endcase
            run_op(1'b1, 1'b0, f, a, '0);
        end

        // sign bits of byte and halfword in all four combinations
        for (int n = 0; n < N_EXT; n++) begin
            draw(32, a);
            draw(32, d);
            d[7]  = n[0];
            d[15] = n[1];
            run_op(1'b0, 1'b1, SW, a, d);
            for (int c = 0; c < 4; c++) begin
                run_op(1'b1, 1'b0, ext_codes[c], a, '0);
            end
        end

        // byte and halfword stores, then read the whole word
        for (int n = 0; n < N_SUB; n++) begin
            draw(32, a);
            draw(32, d);
            draw(1, r);
            f = r[0] ? SH : SB;
            run_op(1'b0, 1'b1, f, a, d);
            run_op(1'b1, 1'b0, LW, a, '0);
        end

        // both strobes give a load, then check the word and its alias
        for (int n = 0; n < N_PRIO; n++) begin
            draw(32, a);
            draw(32, d);
            draw(3, r);
            f = func3_t'(r[2:0]);
            run_op(1'b1, 1'b1, f, a, d);
            run_op(1'b1, 1'b0, LW, a, '0);
            draw(6, k);
            run_op(1'b1, 1'b0, LW, MEM_DEPTH + k, '0);
        end

        $display("All tests passed");
        $finish;
    end

endmodule : tb_mem_subsystem

/* files.f */
logic/mem_pkg.sv
logic/data_ram.sv
logic/subword_unit.sv
logic/mem_controller.sv
logic/mem_subsystem_top.sv
testbench/tb_mem_subsystem.sv

/* Bender.yml */
package:
  name: mem_subsystem

sources:
  # package first, then leaf modules, then the top level
  - files:
      - logic/mem_pkg.sv
      - logic/data_ram.sv
      - logic/subword_unit.sv
      - logic/mem_controller.sv
      - logic/mem_subsystem_top.sv

  # testbench for simulation only
  - target: test
    files:
      - testbench/tb_mem_subsystem.sv
